/* run.sh */
#!/usr/bin/env bash
# compile with Verilator and run the testbench
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
   --top-module tb_usb_periph -o sim_tb
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
   exit 1
fi
exit 0

/* src.f */
+incdir+.
usb_fn_pkg.sv
usb_reg_pkg.sv
usb_ctrl.sv
usb_apb_regs.sv
usb_fifo.sv
usb_disk_ram.sv
usb_periph_top.sv
usb_assertions.sv
tb_usb_checker.sv
tb_usb_periph.sv

/* tb_usb_checker.sv */
`timescale 1ns/1ps
`include "usb_defines.svh"

module tb_usb_checker
   import usb_fn_pkg::*;
   import usb_reg_pkg::*;
(
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  logic                    psel_i,
   input  logic                    penable_i,
   input  logic                    pwrite_i,
   input  logic [`USB_APB_AW-1:0]  paddr_i,
   input  logic [`USB_APB_DW-1:0]  pwdata_i,
   input  logic [`USB_APB_DW-1:0]  prdata_i,
   input  logic                    pslverr_i,
   input  logic                    usb_dp_pull_i,
   input  usb_fn_e                 fn_sel_i,
   input  logic                    fn_rst_i,
   input  logic                    fn_rx_valid_i,
   input  rx_payload_t             fn_rx_data_i,
   input  logic                    fn_rx_ready_i,
   input  logic                    fn_tx_valid_i,
   input  tx_payload_t             fn_tx_data_i,
   input  logic                    fn_tx_ready_i,
   input  logic [`USB_DISK_AW-1:0] disk_addr_i,
   input  logic                    disk_wen_i,
   input  logic [`USB_DISK_DW-1:0] disk_wdata_i,
   input  logic [`USB_DISK_DW-1:0] disk_rdata_i,
   output int                      err_cnt_o
);

   rx_payload_t             rx_q[$];   // receive FIFO model
   tx_payload_t             tx_q[$];
   logic [2:0]              sel_m = 3'd0;
   int                      cnt_m = 0;   // reconnect cycles left
   logic [`USB_DISK_DW-1:0] disk_m [`USB_DISK_BYTES];
   logic [`USB_DISK_DW-1:0] rd_exp;
   logic                    rd_known = 1'b0;
   int                      errors = 0;

   assign err_cnt_o = errors;

   initial begin
      for (int i = 0; i < `USB_DISK_BYTES; i++)
         disk_m[i] = '0;
   end

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
      if (got !== exp) begin
         $display("ERROR %s expected 0x%h got 0x%h at %0t", name, exp, got, $time);
         errors++;
      end
   endtask

   always @(posedge clk_i) begin : model_step
      logic        conn, access, exp_err, rx_push, rx_pop, tx_push, tx_pop;
      logic [31:0] exp_rd;
      conn = (cnt_m == 0) && (sel_m != FN_RESET) && (sel_m != FN_RESET2);

      // disk read data lags its address by one cycle
      if (rd_known)
         check_value("disk_rdata_o", 32'(rd_exp), 32'(disk_rdata_i));
      rd_exp   = disk_m[disk_addr_i];
      rd_known = 1'b1;
      if (disk_wen_i && conn && sel_m == FN_DISK)
         disk_m[disk_addr_i] = disk_wdata_i;

      if (rst_i) begin
         sel_m = FN_RESET;
         cnt_m = 0;
         rx_q.delete();
         tx_q.delete();
      end else begin
         check_value("fn_sel_o", 32'(sel_m), 32'(fn_sel_i));
         check_value("fn_rst_o", 32'(cnt_m != 0), 32'(fn_rst_i));
         check_value("usb_dp_pull_o", 32'(conn), 32'(usb_dp_pull_i));
         check_value("fn_rx_ready_o", 32'(conn && rx_q.size() < `USB_RX_DEPTH),
                     32'(fn_rx_ready_i));
         check_value("fn_tx_valid_o", 32'(conn && tx_q.size() > 0), 32'(fn_tx_valid_i));
         if (conn && tx_q.size() > 0)
            check_value("fn_tx_data_o", 32'(tx_q[0]), 32'(fn_tx_data_i));

         access  = psel_i && penable_i;
         exp_err = 1'b0;
         exp_rd  = '0;
         rx_pop  = 1'b0;
         tx_push = 1'b0;
         if (access) begin
            case (paddr_i)
               REG_CCR: exp_rd = '0;
               REG_RDR: begin
                  if (!pwrite_i && rx_q.size() > 0) begin
                     exp_rd = 32'(rx_q[0]);
                     rx_pop = 1'b1;
                  end
               end
               REG_TDR: begin
                  if (pwrite_i && tx_q.size() == `USB_TX_DEPTH)
                     exp_err = 1'b1;   // full, write dropped
                  else if (pwrite_i)
                     tx_push = 1'b1;
               end
               REG_STA: begin
                  exp_rd[STA_CONNECTED] = conn;
                  exp_rd[STA_RX_VALID]  = rx_q.size() > 0;
                  exp_rd[STA_TX_FULL]   = tx_q.size() == `USB_TX_DEPTH;
               end
               default: exp_err = 1'b1;
            endcase
            if (!pwrite_i)
               check_value("prdata_o", exp_rd, prdata_i);
         end
         check_value("pslverr_o", 32'(exp_err), 32'(pslverr_i));

         rx_push = fn_rx_valid_i && conn && rx_q.size() < `USB_RX_DEPTH;
         tx_pop  = fn_tx_ready_i && conn && tx_q.size() > 0;
         if (access && pwrite_i && paddr_i == REG_CCR) begin
            sel_m = pwdata_i[2:0];   // flush wins over any transfer this cycle
            cnt_m = `USB_CONNECT_CYCLES;
            rx_q.delete();
            tx_q.delete();
         end else begin
            if (cnt_m != 0)
               cnt_m--;
            if (rx_pop)
               void'(rx_q.pop_front());
            if (tx_pop)
               void'(tx_q.pop_front());
            if (rx_push)
               rx_q.push_back(fn_rx_data_i);
            if (tx_push)
               tx_q.push_back(tx_payload_t'(pwdata_i));
         end
      end
   end

endmodule

/* tb_usb_periph.sv */
`timescale 1ns/1ps
`include "usb_defines.svh"

module tb_usb_periph
   import usb_fn_pkg::*;
   import usb_reg_pkg::*;
();

   localparam int TIMEOUT = 200;   // cycles per wait

   logic                    clk, rst;
   logic                    psel, penable, pwrite, pready, pslverr;
   logic [`USB_APB_AW-1:0]  paddr;
   logic [`USB_APB_DW-1:0]  pwdata, prdata;
   logic                    pull, fn_rst;
   usb_fn_e                 fn_sel;
   logic                    fn_rx_valid, fn_rx_ready, fn_tx_valid, fn_tx_ready;
   rx_payload_t             fn_rx_data;
   tx_payload_t             fn_tx_data;
   logic [`USB_DISK_AW-1:0] disk_addr;
   logic                    disk_wen;
   logic [`USB_DISK_DW-1:0] disk_wdata, disk_rdata;
   int                      rx_pct, tx_pct, wen_pct;   // function-side activity in percent
   int                      timeouts, err_cnt;

   usb_periph_top u_usb_periph_top (
      .clk_i(clk), .rst_i(rst), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
      .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
      .pslverr_o(pslverr), .usb_dp_pull_o(pull), .fn_sel_o(fn_sel), .fn_rst_o(fn_rst),
      .fn_rx_valid_i(fn_rx_valid), .fn_rx_data_i(fn_rx_data), .fn_rx_ready_o(fn_rx_ready),
      .fn_tx_valid_o(fn_tx_valid), .fn_tx_data_o(fn_tx_data), .fn_tx_ready_i(fn_tx_ready),
      .disk_addr_i(disk_addr), .disk_wen_i(disk_wen), .disk_wdata_i(disk_wdata),
      .disk_rdata_o(disk_rdata)
   );

   tb_usb_checker u_checker (
      .clk_i(clk), .rst_i(rst), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
      .paddr_i(paddr), .pwdata_i(pwdata), .prdata_i(prdata), .pslverr_i(pslverr),
      .usb_dp_pull_i(pull), .fn_sel_i(fn_sel), .fn_rst_i(fn_rst),
      .fn_rx_valid_i(fn_rx_valid), .fn_rx_data_i(fn_rx_data), .fn_rx_ready_i(fn_rx_ready),
      .fn_tx_valid_i(fn_tx_valid), .fn_tx_data_i(fn_tx_data), .fn_tx_ready_i(fn_tx_ready),
      .disk_addr_i(disk_addr), .disk_wen_i(disk_wen), .disk_wdata_i(disk_wdata),
      .disk_rdata_i(disk_rdata), .err_cnt_o(err_cnt)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // function side, new values every cycle
   initial begin
      forever begin
         @(posedge clk);
         #1;
         fn_rx_valid = int'($urandom % 100) < rx_pct;
         fn_rx_data  = rx_payload_t'($urandom);
         fn_tx_ready = int'($urandom % 100) < tx_pct;
         disk_addr   = `USB_DISK_AW'($urandom % 16);   // small window so reads hit writes
         disk_wen    = int'($urandom % 100) < wen_pct;
         disk_wdata  = `USB_DISK_DW'($urandom);
      end
   end

   task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] data);
      int waits;
      @(posedge clk);
      #1;
      psel    = 1'b1;   // setup
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = data;
      @(posedge clk);
      #1;
      penable = 1'b1;   // access
      @(posedge clk);
      waits = 0;
      while (!pready && waits < TIMEOUT) begin
         @(posedge clk);
         waits++;
      end
      if (!pready) begin
         $display("APB transfer to offset %0d never completed", addr);
         timeouts++;
      end
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
      apb_xfer(1'b1, addr, data);
   endtask

   task automatic apb_read(input logic [3:0] addr);
      apb_xfer(1'b0, addr, 32'h0);   // data is checked by the checker
   endtask

   task automatic select_fn(input logic [2:0] code);
      apb_write(REG_CCR, {29'd0, code});
   endtask

   task automatic wait_pull_high();
      int waits;
      waits = 0;
      while (pull !== 1'b1 && waits < TIMEOUT) begin
         @(posedge clk);
         waits++;
      end
      if (pull !== 1'b1) begin
         $display("function did not connect in time");
         timeouts++;
      end
   endtask

   task automatic wait_tx_drain();
      int waits;
      waits = 0;
      while (fn_tx_valid !== 1'b0 && waits < TIMEOUT) begin
         @(posedge clk);
         waits++;
      end
      if (fn_tx_valid !== 1'b0) begin
         $display("transmit FIFO did not drain in time");
         timeouts++;
      end
   endtask

   initial begin
      void'($urandom(36));
      rst         = 1'b1;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      fn_rx_valid = 1'b0;
      fn_rx_data  = '0;
      fn_tx_ready = 1'b0;
      disk_addr   = '0;
      disk_wen    = 1'b0;
      disk_wdata  = '0;
      rx_pct      = 0;
      tx_pct      = 0;
      wen_pct     = 0;
      timeouts    = 0;
      repeat (2) @(posedge clk);
      #1 rst = 1'b0;

      apb_read(REG_STA);   // reset state

      for (int i = 0; i < 4; i++) begin
         select_fn(3'(1 + $urandom % 6));
         wait_pull_high();
         repeat (3) @(posedge clk);
      end
      select_fn(FN_RESET);   // idle codes stay disconnected
      repeat (30) @(posedge clk);
      select_fn(FN_RESET2);
      repeat (30) @(posedge clk);
      apb_read(4'd2);
      apb_write(4'd6, 32'h1);

      // receive path, fill to full then drain past empty
      select_fn(FN_SERIAL);
      wait_pull_high();
      rx_pct = 100;
      repeat (20) @(posedge clk);
      rx_pct = 0;
      apb_read(REG_STA);
      repeat (`USB_RX_DEPTH + 1) apb_read(REG_RDR);
      rx_pct = 40;
      repeat (40) apb_read(($urandom % 2) ? REG_RDR : REG_STA);
      rx_pct = 0;
      repeat (10) apb_read(REG_RDR);

      // transmit path, last of the first burst hits a full FIFO
      repeat (`USB_TX_DEPTH + 1) apb_write(REG_TDR, $urandom);
      apb_read(REG_STA);   // tx_full set here
      tx_pct = 60;
      repeat (30) apb_write(REG_TDR, $urandom);
      wait_tx_drain();

      // reselection drops everything queued before it
      tx_pct = 0;
      rx_pct = 100;
      repeat (4) apb_write(REG_TDR, $urandom);
      select_fn(FN_KEYBOARD);
      rx_pct = 0;
      wait_pull_high();
      tx_pct = 100;
      repeat (5) @(posedge clk);
      repeat (2) apb_read(REG_RDR);

      // disk writes only land while disk is connected
      wen_pct = 50;
      select_fn(FN_DISK);
      wait_pull_high();
      repeat (60) @(posedge clk);
      select_fn(FN_AUDIO);
      repeat (40) @(posedge clk);
      wen_pct = 0;
      select_fn(FN_DISK);
      wait_pull_high();
      repeat (40) @(posedge clk);

      $display("checks done: %0d mismatches, %0d timeouts", err_cnt, timeouts);
      if (err_cnt == 0 && timeouts == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

   // overall limit in case a wait loop is never entered correctly
   initial begin
      #200000;
      $display("simulation ran past its overall time limit");
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

/* usb_apb_regs.sv */
`timescale 1ns/1ps
`include "usb_defines.svh"

module usb_apb_regs
   import usb_fn_pkg::*;
   import usb_reg_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   psel_i,
   input  logic                   penable_i,
   input  logic                   pwrite_i,
   input  logic [`USB_APB_AW-1:0] paddr_i,
   input  logic [`USB_APB_DW-1:0] pwdata_i,
   output logic [`USB_APB_DW-1:0] prdata_o,
   output logic                   pready_o,
   output logic                   pslverr_o,
   input  logic                   connected_i,
   input  logic                   rx_valid_i,
   input  rx_payload_t            rx_data_i,
   output logic                   rx_pop_o,
   input  logic                   tx_full_i,
   output logic                   tx_push_o,
   output tx_payload_t            tx_data_o,
   output logic                   sel_wr_o,
   output usb_fn_e                sel_code_o
);

   usb_reg_e reg_sel;
   logic     setup_q;      // previous cycle was a setup phase
   logic     access;
   logic     mapped;

   always_ff @(posedge clk_i) begin
      if (rst_i) setup_q <= 1'b0;
      else       setup_q <= psel_i && !penable_i;
   end

   // only a genuine setup->access pair counts, one strobe per transfer
   assign access  = psel_i && penable_i && setup_q;
   assign reg_sel = usb_reg_e'(paddr_i);
   assign mapped  = (reg_sel == REG_CCR) || (reg_sel == REG_RDR) ||
                    (reg_sel == REG_TDR) || (reg_sel == REG_STA);

   assign sel_wr_o   = access && pwrite_i && (reg_sel == REG_CCR);
   assign sel_code_o = usb_fn_e'(pwdata_i[2:0]);

   assign tx_data_o  = pwdata_i[`USB_TX_W-1:0];
   assign tx_push_o  = access && pwrite_i && (reg_sel == REG_TDR) && !tx_full_i;

   // empty read does not pop
   assign rx_pop_o   = access && !pwrite_i && (reg_sel == REG_RDR) && rx_valid_i;

   assign pready_o   = 1'b1;   // no wait states
   assign pslverr_o  = access && (!mapped ||
                                  (pwrite_i && (reg_sel == REG_TDR) && tx_full_i));

   // read mux, zero outside a read access
   always_comb begin
      prdata_o = '0;
      if (access && !pwrite_i) begin
         case (reg_sel)
            REG_RDR: begin
               if (rx_valid_i)
                  prdata_o[`USB_RX_W-1:0] = rx_data_i;
            end
            REG_STA: begin
               prdata_o[STA_CONNECTED] = connected_i;
               prdata_o[STA_RX_VALID]  = rx_valid_i;
               prdata_o[STA_TX_FULL]   = tx_full_i;
            end
            default: prdata_o = '0;   // ccr and tdr read as zero
         endcase
      end
   end

endmodule

/* usb_assertions.sv */
`timescale 1ns/1ps

module usb_assertions (
   input logic clk_i,
   input logic rst_i,
   input logic pready_i,
   input logic pslverr_i,
   input logic tx_valid_i,
   input logic tx_ready_i,
   input logic rx_ready_i,
   input logic flush_i,     // reselection empties the transmit FIFO
   input logic fn_rst_i,
   input logic pull_i
);

   a_pready_high: assert property (@(posedge clk_i) disable iff (rst_i) pready_i)
      else $error("pready went low");

   a_tx_valid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      tx_valid_i && !tx_ready_i && !flush_i |=> tx_valid_i)
      else $error("transmit valid dropped before the word was accepted");

   a_reset_quiet: assert property (@(posedge clk_i)
      rst_i |=> !(fn_rst_i || pull_i || rx_ready_i || tx_valid_i || pslverr_i))
      else $error("control output active right after a reset cycle");

   a_pull_after_rst: assert property (@(posedge clk_i) disable iff (rst_i)
      !(pull_i && fn_rst_i))
      else $error("pull-up on while the function is still in reset");

endmodule

bind usb_periph_top usb_assertions u_assertions (
   .clk_i(clk_i), .rst_i(rst_i), .pready_i(pready_o), .pslverr_i(pslverr_o),
   .tx_valid_i(fn_tx_valid_o), .tx_ready_i(fn_tx_ready_i), .rx_ready_i(fn_rx_ready_o),
   .flush_i(flush), .fn_rst_i(fn_rst_o), .pull_i(usb_dp_pull_o)
);

/* usb_ctrl.sv */
`timescale 1ns/1ps
`include "usb_defines.svh"

module usb_ctrl
   import usb_fn_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_i,
   input  logic    sel_wr_i,      // ccr write strobe
   input  usb_fn_e sel_code_i,
   output usb_fn_e fn_sel_o,
   output logic    fn_rst_o,
   output logic    connected_o,
   output logic    usb_dp_pull_o,
   output logic    flush_o
);

   localparam int CNT_W = $clog2(`USB_CONNECT_CYCLES + 1);

   usb_fn_e            fn_sel_q;
   logic [CNT_W-1:0]   rst_cnt_q;   // cycles of function reset left
   logic               idle_code;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         fn_sel_q  <= FN_RESET;
         rst_cnt_q <= '0;
      end else if (sel_wr_i) begin
         fn_sel_q  <= sel_code_i;
         rst_cnt_q <= CNT_W'(`USB_CONNECT_CYCLES); // restart reconnect sequence
      end else if (rst_cnt_q != '0) begin
         rst_cnt_q <= rst_cnt_q - 1'b1;
      end
   end

   // codes 0 and 7 park the device, never connect
   assign idle_code = (fn_sel_q == FN_RESET) || (fn_sel_q == FN_RESET2);

   assign fn_sel_o  = fn_sel_q;
   assign fn_rst_o  = (rst_cnt_q != '0);

   // connect on the cycle after the reset window closes
   assign connected_o   = !fn_rst_o && !idle_code;
   assign usb_dp_pull_o = connected_o;

   // flush takes effect on the same edge that loads the new code
   assign flush_o = sel_wr_i;

endmodule

/* usb_defines.svh */
`ifndef USB_DEFINES_SVH
`define USB_DEFINES_SVH

`define USB_RX_DEPTH       8    // receive fifo entries
`define USB_TX_DEPTH       8    // transmit fifo entries
`define USB_DISK_BYTES     256
`define USB_DISK_AW        8    // log2 of disk size
`define USB_DISK_DW        8
`define USB_CONNECT_CYCLES 16   // function reset length before connect
`define USB_APB_AW         4
`define USB_APB_DW         32
`define USB_RX_W           8    // one byte per receive unit
`define USB_TX_W           16   // keyboard report or audio sample

`endif

/* usb_disk_ram.sv */
`timescale 1ns/1ps
`include "usb_defines.svh"

module usb_disk_ram (
   input  logic                    clk_i,
   input  logic [`USB_DISK_AW-1:0] addr_i,
   input  logic                    wen_i,
   input  logic                    en_i,     // disk selected and connected
   input  logic [`USB_DISK_DW-1:0] wdata_i,
   output logic [`USB_DISK_DW-1:0] rdata_o
);

   logic [`USB_DISK_DW-1:0] mem [`USB_DISK_BYTES];

   initial begin
      for (int i = 0; i < `USB_DISK_BYTES; i++)
         mem[i] = '0;
   end

   always_ff @(posedge clk_i) begin
      if (wen_i && en_i)
         mem[addr_i] <= wdata_i;
      rdata_o <= mem[addr_i];   // read before write
   end

endmodule

/* usb_fifo.sv */
`timescale 1ns/1ps

module usb_fifo #(
   parameter type T     = logic [7:0],
   parameter int  DEPTH = 8
) (
   input  logic clk_i,
   input  logic rst_i,
   input  logic flush_i,
   input  logic push_i,
   input  T     data_i,
   input  logic pop_i,
   output T     data_o,
   output logic empty_o,
   output logic full_o
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   T                mem [DEPTH];
   logic [AW-1:0]   wr_ptr_q;
   logic [AW-1:0]   rd_ptr_q;
   logic [AW:0]     count_q;
   logic            push_ok;
   logic            pop_ok;

   assign push_ok = push_i && !full_o;   // push to full dropped
   assign pop_ok  = pop_i && !empty_o;

   always_ff @(posedge clk_i) begin
      if (rst_i || flush_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_ok)
            wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (pop_ok)
            rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         count_q <= count_q + (AW + 1)'(push_ok) - (AW + 1)'(pop_ok);
      end
   end

   always_ff @(posedge clk_i) begin
      if (push_ok) mem[wr_ptr_q] <= data_i;
   end

   assign data_o  = mem[rd_ptr_q];   // show-ahead head
   assign empty_o = (count_q == '0);
   assign full_o  = (count_q == (AW + 1)'(DEPTH));

endmodule

/* usb_fn_pkg.sv */
`include "usb_defines.svh"

package usb_fn_pkg;

   // function codes as written to CCR[2:0]
   typedef enum logic [2:0] {
      FN_RESET    = 3'd0,   // idle
      FN_AUDIO    = 3'd1,
      FN_CAMERA   = 3'd2,
      FN_DISK     = 3'd3,
      FN_KEYBOARD = 3'd4,
      FN_SERIAL   = 3'd5,
      FN_SERIAL2  = 3'd6,
      FN_RESET2   = 3'd7    // second idle code
   } usb_fn_e;

   // function to cpu, one byte
   typedef logic [`USB_RX_W-1:0] rx_payload_t;

   // cpu to function; serial only looks at the low byte
   typedef logic [`USB_TX_W-1:0] tx_payload_t;

endpackage

/* usb_periph_top.sv */
`timescale 1ns/1ps
`include "usb_defines.svh"

module usb_periph_top
   import usb_fn_pkg::*;
(
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  logic                    psel_i,
   input  logic                    penable_i,
   input  logic                    pwrite_i,
   input  logic [`USB_APB_AW-1:0]  paddr_i,
   input  logic [`USB_APB_DW-1:0]  pwdata_i,
   output logic [`USB_APB_DW-1:0]  prdata_o,
   output logic                    pready_o,
   output logic                    pslverr_o,
   output logic                    usb_dp_pull_o,
   output usb_fn_e                 fn_sel_o,
   output logic                    fn_rst_o,
   input  logic                    fn_rx_valid_i,
   input  rx_payload_t             fn_rx_data_i,
   output logic                    fn_rx_ready_o,
   output logic                    fn_tx_valid_o,
   output tx_payload_t             fn_tx_data_o,
   input  logic                    fn_tx_ready_i,
   input  logic [`USB_DISK_AW-1:0] disk_addr_i,
   input  logic                    disk_wen_i,
   input  logic [`USB_DISK_DW-1:0] disk_wdata_i,
   output logic [`USB_DISK_DW-1:0] disk_rdata_o
);

   logic        connected, flush;
   logic        sel_wr;
   usb_fn_e     sel_code;
   logic        rx_pop, rx_empty, rx_full;
   rx_payload_t rx_head;
   logic        tx_push, tx_empty, tx_full;
   tx_payload_t tx_wdata;
   logic        disk_en;

   usb_ctrl u_ctrl (
      .clk_i, .rst_i,
      .sel_wr_i(sel_wr), .sel_code_i(sel_code),
      .fn_sel_o, .fn_rst_o, .connected_o(connected),
      .usb_dp_pull_o, .flush_o(flush)
   );

   usb_apb_regs u_regs (
      .clk_i, .rst_i,
      .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
      .prdata_o, .pready_o, .pslverr_o,
      .connected_i(connected),
      .rx_valid_i(!rx_empty), .rx_data_i(rx_head), .rx_pop_o(rx_pop),
      .tx_full_i(tx_full), .tx_push_o(tx_push), .tx_data_o(tx_wdata),
      .sel_wr_o(sel_wr), .sel_code_o(sel_code)
   );

   // handshakes only open while the function is connected
   assign fn_rx_ready_o = connected && !rx_full;
   assign fn_tx_valid_o = connected && !tx_empty;

   usb_fifo #(.T(rx_payload_t), .DEPTH(`USB_RX_DEPTH)) u_rx_fifo (
      .clk_i, .rst_i, .flush_i(flush),
      .push_i(fn_rx_valid_i && fn_rx_ready_o), .data_i(fn_rx_data_i),
      .pop_i(rx_pop), .data_o(rx_head),
      .empty_o(rx_empty), .full_o(rx_full)
   );

   usb_fifo #(.T(tx_payload_t), .DEPTH(`USB_TX_DEPTH)) u_tx_fifo (
      .clk_i, .rst_i, .flush_i(flush),
      .push_i(tx_push), .data_i(tx_wdata),
      .pop_i(fn_tx_valid_o && fn_tx_ready_i), .data_o(fn_tx_data_o),
      .empty_o(tx_empty), .full_o(tx_full)
   );

   assign disk_en = connected && (fn_sel_o == FN_DISK);

   usb_disk_ram u_disk_ram (
      .clk_i,
      .addr_i(disk_addr_i), .wen_i(disk_wen_i), .en_i(disk_en),
      .wdata_i(disk_wdata_i), .rdata_o(disk_rdata_o)
   );

endmodule

/* usb_reg_pkg.sv */
`include "usb_defines.svh"

package usb_reg_pkg;

   // byte offsets on the apb bus
   typedef enum logic [`USB_APB_AW-1:0] {
      REG_CCR = 4'd0,    // function select
      REG_RDR = 4'd4,    // receive data, read pops
      REG_TDR = 4'd8,    // transmit data, write pushes
      REG_STA = 4'd12    // status
   } usb_reg_e;

   // status register bits
   localparam int STA_CONNECTED = 0;
   localparam int STA_RX_VALID  = 1;
   localparam int STA_TX_FULL   = 2;

endpackage
